// File: rtl/can_reg_pkg.sv
// CAN register block shared definitions
// register map, field widths, bit positions, reset values and the mode byte layout
package can_reg_pkg;

  //////////////////////////////////////////////////
  // widths fixed by the register map
  localparam int BYTE_W = 8;
  localparam int CMD_W  = 5;
  localparam int CD_W   = 3;

  typedef logic [BYTE_W-1:0] byte_t;

  // mode register, one stored byte read through two layouts
  typedef union packed {
    // basic mode: host interrupt enables live here
    struct packed {
      logic [2:0] unused;
      logic       overrun_ie;
      logic       error_ie;
      logic       tx_ie;
      logic       rx_ie;
      logic       reset;
    } basic;
    // extended mode: operating options, locked outside reset mode
    struct packed {
      logic [3:0] unused;
      logic       acc_filter;
      logic       self_test;
      logic       listen_only;
      logic       reset;
    } ext;
  } mode_reg_u;

  //////////////////////////////////////////////////
  // register addresses
  localparam byte_t ADDR_MODE      = 8'd0;
  localparam byte_t ADDR_COMMAND   = 8'd1;
  localparam byte_t ADDR_STATUS    = 8'd2;
  localparam byte_t ADDR_IRQ       = 8'd3;
  localparam byte_t ADDR_IRQ_EN    = 8'd4;
  localparam byte_t ADDR_CLOCK_DIV = 8'd31;

  // command register bits
  localparam int CMD_TX_REQ      = 0;
  localparam int CMD_ABORT       = 1;
  localparam int CMD_RELEASE     = 2;
  localparam int CMD_CLR_OVERRUN = 3;
  localparam int CMD_SELF_RX     = 4;

  // interrupt register bits, bit 4 has no source
  localparam int IRQ_RX          = 0;
  localparam int IRQ_TX          = 1;
  localparam int IRQ_ERR         = 2;
  localparam int IRQ_OVERRUN     = 3;
  localparam int IRQ_ERR_PASSIVE = 5;
  localparam int IRQ_ARB_LOST    = 6;
  localparam int IRQ_BUS_ERR     = 7;

  //////////////////////////////////////////////////
  // constants and reset values
  localparam byte_t           MODE_RESET      = 8'h01;
  localparam logic [2:0]      BASIC_MODE_FILL = 3'b001;
  localparam logic [3:0]      BASIC_IRQ_FILL  = 4'he;
  localparam logic [CD_W-1:0] CLKDIV_BYPASS   = 3'b111;

endpackage

// File: rtl/can_mode_cmd.sv
// CAN mode and command registers
// mode byte with reset bit, self-clearing command bits and transmit request flags
`timescale 1ns/1ps

module can_mode_cmd (
  input  logic                   clk,
  input  logic                   rst,
  input  can_reg_pkg::byte_t     data_in,
  input  logic                   we_mode,
  input  logic                   we_command,
  input  logic                   set_reset_mode,
  input  logic                   sample_point,
  input  logic                   transmitting,
  input  logic                   tx_state,
  input  logic                   tx_state_q,
  input  logic                   extended_mode,
  output can_reg_pkg::mode_reg_u mode,
  output logic                   reset_mode,
  output logic                   listen_only_mode,
  output logic                   self_test_mode,
  output logic                   acceptance_filter_mode,
  output logic                   tx_request,
  output logic                   abort_tx,
  output logic                   release_buffer,
  output logic                   clear_data_overrun,
  output logic                   self_rx_request,
  output logic                   single_shot_transmission
);

  logic [can_reg_pkg::CMD_W-1:0] command;
  logic [can_reg_pkg::CMD_W-1:0] cmd_clr;
  logic                          tx_done;

  //////////////////////////////////////////////////
  // mode register
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      mode <= can_reg_pkg::MODE_RESET;
    else
    begin
      // core forces reset mode, e.g. on bus off
      if (set_reset_mode)
        mode.basic.reset <= 1'b1;
      else if (we_mode)
        mode.basic.reset <= data_in[0];
      // extended options only change while held in reset
      if (we_mode && (reset_mode || !extended_mode))
        mode[4:1] <= data_in[4:1];
    end
  end

  assign reset_mode             = mode.basic.reset;
  assign listen_only_mode       = extended_mode & mode.ext.listen_only;
  assign self_test_mode         = extended_mode & mode.ext.self_test;
  assign acceptance_filter_mode = extended_mode & mode.ext.acc_filter;

  //////////////////////////////////////////////////
  // command register
  // request bits hold until the core samples them
  assign cmd_clr[can_reg_pkg::CMD_TX_REQ]      = command[can_reg_pkg::CMD_TX_REQ] & sample_point;
  assign cmd_clr[can_reg_pkg::CMD_ABORT]       = sample_point &
                                                 (tx_request | (abort_tx & ~transmitting));
  assign cmd_clr[can_reg_pkg::CMD_SELF_RX]     = command[can_reg_pkg::CMD_SELF_RX] & sample_point;
  // release and clear overrun are one-cycle pulses
  assign cmd_clr[can_reg_pkg::CMD_RELEASE]     = command[can_reg_pkg::CMD_RELEASE] |
                                                 command[can_reg_pkg::CMD_CLR_OVERRUN];
  assign cmd_clr[can_reg_pkg::CMD_CLR_OVERRUN] = cmd_clr[can_reg_pkg::CMD_RELEASE];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      command <= '0;
    else
    begin
      // clear wins over a write in the same cycle
      for (int i = 0; i < can_reg_pkg::CMD_W; i++)
      begin
        if (cmd_clr[i] || reset_mode)
          command[i] <= 1'b0;
        else if (we_command)
          command[i] <= data_in[i];
      end
    end
  end

  assign tx_request         = command[can_reg_pkg::CMD_TX_REQ] | command[can_reg_pkg::CMD_SELF_RX];
  assign abort_tx           = command[can_reg_pkg::CMD_ABORT] & ~tx_request;
  assign release_buffer     = command[can_reg_pkg::CMD_RELEASE];
  assign clear_data_overrun = command[can_reg_pkg::CMD_CLR_OVERRUN];

  // end of a transmission in the core
  assign tx_done = ~tx_state & tx_state_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      self_rx_request          <= 1'b0;
      single_shot_transmission <= 1'b0;
    end
    else
    begin
      // self reception only when no normal request came with it
      if (command[can_reg_pkg::CMD_SELF_RX] & ~command[can_reg_pkg::CMD_TX_REQ])
        self_rx_request <= 1'b1;
      else if (tx_done)
        self_rx_request <= 1'b0;
      // request plus abort means a single attempt
      if (tx_request & command[can_reg_pkg::CMD_ABORT] & sample_point)
        single_shot_transmission <= 1'b1;
      else if (tx_done)
        single_shot_transmission <= 1'b0;
    end
  end

endmodule

// File: rtl/can_status.sv
// CAN status register
// keeps the four host-side status flags and packs them with the live core status
`timescale 1ns/1ps

module can_status (
  input  logic               clk,
  input  logic               rst,
  input  logic               reset_mode,
  input  logic               tx_request,
  input  logic               abort_tx,
  input  logic               release_buffer,
  input  logic               clear_data_overrun,
  input  logic               tx_successful,
  input  logic               need_to_tx,
  input  logic               overrun,
  input  logic               info_empty,
  input  logic               node_bus_off,
  input  logic               error_status,
  input  logic               transmit_status,
  input  logic               receive_status,
  output can_reg_pkg::byte_t status,
  output logic               transmit_buffer_status
);

  logic tx_successful_q;
  logic overrun_q;
  logic transmission_complete;
  logic overrun_status;
  logic receive_buffer_status;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      tx_successful_q        <= 1'b0;
      overrun_q              <= 1'b0;
      transmission_complete  <= 1'b1;
      transmit_buffer_status <= 1'b1;
      overrun_status         <= 1'b0;
      receive_buffer_status  <= 1'b0;
    end
    else
    begin
      // previous values for edge detection
      tx_successful_q <= tx_successful;
      overrun_q       <= overrun;
      // complete on a finished frame or an accepted abort
      if ((tx_successful & ~tx_successful_q) | abort_tx)
        transmission_complete <= 1'b1;
      else if (tx_request)
        transmission_complete <= 1'b0;
      // buffer locked while a request is pending
      if (tx_request)
        transmit_buffer_status <= 1'b0;
      else if (reset_mode || !need_to_tx)
        transmit_buffer_status <= 1'b1;
      if (overrun & ~overrun_q)
        overrun_status <= 1'b1;
      else if (reset_mode || clear_data_overrun)
        overrun_status <= 1'b0;
      // release drops the flag for one cycle, it comes back if more frames wait
      if (reset_mode || release_buffer)
        receive_buffer_status <= 1'b0;
      else if (!info_empty)
        receive_buffer_status <= 1'b1;
    end
  end

  assign status = {node_bus_off, error_status, transmit_status, receive_status,
                   transmission_complete, transmit_buffer_status, overrun_status,
                   receive_buffer_status};

endmodule

// File: rtl/can_irq.sv
// CAN interrupt logic
// enable register, seven interrupt flags with clear-on-read and the irq_n line
`timescale 1ns/1ps

module can_irq (
  input  logic                   clk,
  input  logic                   rst,
  input  can_reg_pkg::byte_t     data_in,
  input  logic                   we_irq_en,
  input  logic                   read_irq_reg,
  input  can_reg_pkg::mode_reg_u mode,
  input  logic                   extended_mode,
  input  logic                   reset_mode,
  input  logic                   release_buffer,
  input  logic                   transmit_buffer_status,
  input  logic                   overrun,
  input  logic                   info_empty,
  input  logic                   error_status,
  input  logic                   node_bus_off,
  input  logic                   node_error_passive,
  input  logic                   node_error_active,
  input  logic                   set_bus_error_irq,
  input  logic                   set_arbitration_lost_irq,
  output can_reg_pkg::byte_t     irq_en,
  output can_reg_pkg::byte_t     irq_reg,
  output logic                   irq_n
);

  logic rx_en;
  logic tx_en;
  logic err_en;
  logic overrun_en;
  logic overrun_q;
  logic tbs_q;
  logic error_status_q;
  logic node_bus_off_q;
  logic node_error_passive_q;
  logic set_err_passive;

  // enable register, written in extended mode only
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      irq_en <= '0;
    else if (we_irq_en)
      irq_en <= data_in;
  end

  // four sources exist in both modes, basic keeps their enables in the mode byte
  assign rx_en      = extended_mode ? irq_en[can_reg_pkg::IRQ_RX] : mode.basic.rx_ie;
  assign tx_en      = extended_mode ? irq_en[can_reg_pkg::IRQ_TX] : mode.basic.tx_ie;
  assign err_en     = extended_mode ? irq_en[can_reg_pkg::IRQ_ERR] : mode.basic.error_ie;
  assign overrun_en = extended_mode ? irq_en[can_reg_pkg::IRQ_OVERRUN] : mode.basic.overrun_ie;

  // entering error passive, or going back to active
  assign set_err_passive = (node_error_passive & ~node_error_passive_q) |
                           (~node_error_passive & node_error_passive_q & node_error_active);

  //////////////////////////////////////////////////
  // interrupt flags
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      overrun_q            <= 1'b0;
      tbs_q                <= 1'b1;
      error_status_q       <= 1'b0;
      node_bus_off_q       <= 1'b0;
      node_error_passive_q <= 1'b0;
      irq_reg              <= '0;
    end
    else
    begin
      overrun_q            <= overrun;
      tbs_q                <= transmit_buffer_status;
      error_status_q       <= error_status;
      node_bus_off_q       <= node_bus_off;
      node_error_passive_q <= node_error_passive;
      // receive follows the buffer, not the register read
      if (~info_empty & ~irq_reg[can_reg_pkg::IRQ_RX] & rx_en)
        irq_reg[can_reg_pkg::IRQ_RX] <= 1'b1;
      else if (reset_mode || release_buffer)
        irq_reg[can_reg_pkg::IRQ_RX] <= 1'b0;
      // transmit: a read in the same cycle wins
      if (reset_mode || read_irq_reg)
        irq_reg[can_reg_pkg::IRQ_TX] <= 1'b0;
      else if (transmit_buffer_status & ~tbs_q & tx_en)
        irq_reg[can_reg_pkg::IRQ_TX] <= 1'b1;
      // error warning on any change of error or bus off state, survives reset mode
      if (((error_status ^ error_status_q) | (node_bus_off ^ node_bus_off_q)) & err_en)
        irq_reg[can_reg_pkg::IRQ_ERR] <= 1'b1;
      else if (read_irq_reg)
        irq_reg[can_reg_pkg::IRQ_ERR] <= 1'b0;
      if (overrun & ~overrun_q & overrun_en)
        irq_reg[can_reg_pkg::IRQ_OVERRUN] <= 1'b1;
      else if (reset_mode || read_irq_reg)
        irq_reg[can_reg_pkg::IRQ_OVERRUN] <= 1'b0;
      if (set_err_passive & irq_en[can_reg_pkg::IRQ_ERR_PASSIVE])
        irq_reg[can_reg_pkg::IRQ_ERR_PASSIVE] <= 1'b1;
      else if (reset_mode || read_irq_reg)
        irq_reg[can_reg_pkg::IRQ_ERR_PASSIVE] <= 1'b0;
      if (set_arbitration_lost_irq & irq_en[can_reg_pkg::IRQ_ARB_LOST])
        irq_reg[can_reg_pkg::IRQ_ARB_LOST] <= 1'b1;
      else if (reset_mode || read_irq_reg)
        irq_reg[can_reg_pkg::IRQ_ARB_LOST] <= 1'b0;
      if (set_bus_error_irq & irq_en[can_reg_pkg::IRQ_BUS_ERR])
        irq_reg[can_reg_pkg::IRQ_BUS_ERR] <= 1'b1;
      else if (reset_mode || read_irq_reg)
        irq_reg[can_reg_pkg::IRQ_BUS_ERR] <= 1'b0;
    end
  end

  // line released for a cycle on every read so edge-triggered hosts see a new edge
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      irq_n <= 1'b1;
    else if (read_irq_reg || release_buffer)
      irq_n <= 1'b1;
    else if (|irq_reg)
      irq_n <= 1'b0;
  end

endmodule

// File: rtl/can_clkout.sv
// CAN clock divider register
// holds the extended mode and clock-off bits and divides clk for clkout
`timescale 1ns/1ps

module can_clkout (
  input  logic               clk,
  input  logic               rst,
  input  can_reg_pkg::byte_t data_in,
  input  logic               we_clkdiv_low,
  input  logic               we_clkdiv_high,
  output can_reg_pkg::byte_t clock_divider,
  output logic               extended_mode,
  output logic               clkout
);

  logic                         clock_off;
  logic [can_reg_pkg::CD_W-1:0] cd;
  logic [can_reg_pkg::CD_W-1:0] clkout_div;
  logic [can_reg_pkg::CD_W-1:0] clkout_cnt;
  logic                         clkout_tmp;
  logic                         bypass;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      extended_mode <= 1'b0;
      clock_off     <= 1'b0;
      cd            <= '0;
    end
    else
    begin
      // mode and clock-off only change in reset mode
      if (we_clkdiv_high)
      begin
        extended_mode <= data_in[7];
        clock_off     <= data_in[3];
      end
      if (we_clkdiv_low)
        cd <= data_in[2:0];
    end
  end

  // bits 6..4 have no storage
  assign clock_divider = {extended_mode, 3'b000, clock_off, cd};

  //////////////////////////////////////////////////
  // divider, half period is cd+1 clocks
  assign bypass     = (cd == can_reg_pkg::CLKDIV_BYPASS);
  assign clkout_div = bypass ? '0 : cd;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      clkout_cnt <= '0;
      clkout_tmp <= 1'b0;
    end
    else if (clkout_cnt == clkout_div)
    begin
      clkout_cnt <= '0;
      clkout_tmp <= ~clkout_tmp;
    end
    else
      clkout_cnt <= clkout_cnt + 1'b1;
  end

  // mux rather than a gate on clk
  assign clkout = clock_off ? 1'b1 : (bypass ? clk : clkout_tmp);

endmodule

// File: rtl/can_registers.sv
// CAN host register block
// write decode, readback multiplexer for basic and extended mode, register submodules
`timescale 1ns/1ps

module can_registers (
  input  logic               clk,
  input  logic               rst,
  input  logic               re,
  input  logic               we,
  input  can_reg_pkg::byte_t addr_read,
  input  can_reg_pkg::byte_t addr_write,
  input  can_reg_pkg::byte_t data_in,
  input  logic               sample_point,
  input  logic               transmitting,
  input  logic               set_reset_mode,
  input  logic               node_bus_off,
  input  logic               error_status,
  input  logic               transmit_status,
  input  logic               receive_status,
  input  logic               tx_successful,
  input  logic               need_to_tx,
  input  logic               overrun,
  input  logic               info_empty,
  input  logic               set_bus_error_irq,
  input  logic               set_arbitration_lost_irq,
  input  logic               node_error_passive,
  input  logic               node_error_active,
  input  logic               tx_state,
  input  logic               tx_state_q,
  output can_reg_pkg::byte_t data_out,
  output logic               irq_n,
  output logic               clkout,
  output logic               extended_mode,
  output logic               reset_mode,
  output logic               listen_only_mode,
  output logic               acceptance_filter_mode,
  output logic               self_test_mode,
  output logic               clear_data_overrun,
  output logic               release_buffer,
  output logic               abort_tx,
  output logic               tx_request,
  output logic               self_rx_request,
  output logic               single_shot_transmission
);

  can_reg_pkg::mode_reg_u mode;
  can_reg_pkg::byte_t     status;
  can_reg_pkg::byte_t     irq_en;
  can_reg_pkg::byte_t     irq_reg;
  can_reg_pkg::byte_t     clock_divider;
  logic                   transmit_buffer_status;
  logic                   we_mode;
  logic                   we_command;
  logic                   we_irq_en;
  logic                   we_clkdiv_low;
  logic                   we_clkdiv_high;
  logic                   read_irq_reg;

  //////////////////////////////////////////////////
  // write decode and read strobe
  assign we_mode        = we & (addr_write == can_reg_pkg::ADDR_MODE);
  assign we_command     = we & (addr_write == can_reg_pkg::ADDR_COMMAND);
  assign we_irq_en      = we & (addr_write == can_reg_pkg::ADDR_IRQ_EN) & extended_mode;
  assign we_clkdiv_low  = we & (addr_write == can_reg_pkg::ADDR_CLOCK_DIV);
  assign we_clkdiv_high = we_clkdiv_low & reset_mode;
  // reading the interrupt register clears most flags
  assign read_irq_reg   = re & (addr_read == can_reg_pkg::ADDR_IRQ);

  can_mode_cmd i_mode_cmd (
    .clk, .rst, .data_in, .we_mode, .we_command, .set_reset_mode, .sample_point,
    .transmitting, .tx_state, .tx_state_q, .extended_mode, .mode, .reset_mode,
    .listen_only_mode, .self_test_mode, .acceptance_filter_mode, .tx_request,
    .abort_tx, .release_buffer, .clear_data_overrun, .self_rx_request,
    .single_shot_transmission
  );

  can_status i_status (
    .clk, .rst, .reset_mode, .tx_request, .abort_tx, .release_buffer,
    .clear_data_overrun, .tx_successful, .need_to_tx, .overrun, .info_empty,
    .node_bus_off, .error_status, .transmit_status, .receive_status, .status,
    .transmit_buffer_status
  );

  can_irq i_irq (
    .clk, .rst, .data_in, .we_irq_en, .read_irq_reg, .mode, .extended_mode,
    .reset_mode, .release_buffer, .transmit_buffer_status, .overrun, .info_empty,
    .error_status, .node_bus_off, .node_error_passive, .node_error_active,
    .set_bus_error_irq, .set_arbitration_lost_irq, .irq_en, .irq_reg, .irq_n
  );

  can_clkout i_clkout (
    .clk, .rst, .data_in, .we_clkdiv_low, .we_clkdiv_high, .clock_divider,
    .extended_mode, .clkout
  );

  //////////////////////////////////////////////////
  // readback, combinational from addr_read
  always_comb
  begin
    data_out = '0;
    case (addr_read)
      can_reg_pkg::ADDR_MODE:
        if (extended_mode)
          data_out = {4'h0, mode.ext.acc_filter, mode.ext.self_test,
                      mode.ext.listen_only, mode.ext.reset};
        else
          data_out = {can_reg_pkg::BASIC_MODE_FILL, mode.basic.overrun_ie,
                      mode.basic.error_ie, mode.basic.tx_ie, mode.basic.rx_ie,
                      mode.basic.reset};
      // command is write only, basic mode reads it as all ones
      can_reg_pkg::ADDR_COMMAND:
        data_out = extended_mode ? 8'h00 : 8'hff;
      can_reg_pkg::ADDR_STATUS:
        data_out = status;
      can_reg_pkg::ADDR_IRQ:
        data_out = extended_mode ? irq_reg : {can_reg_pkg::BASIC_IRQ_FILL, irq_reg[3:0]};
      can_reg_pkg::ADDR_IRQ_EN:
        data_out = extended_mode ? irq_en : 8'h00;
      can_reg_pkg::ADDR_CLOCK_DIV:
        data_out = clock_divider;
      default:
        data_out = '0;
    endcase
  end

endmodule

// File: verification/can_registers_tb.sv
// testbench for the CAN host register block
// applies a table of bus writes, reads, input changes and output checks row by row
`timescale 1ns/1ps

module can_registers_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 5;
  localparam int SAMPLE_LEAD  = 2;
  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 16;
  localparam int MAX_ROWS     = 80;

  // row operations
  localparam logic [2:0] OP_WRITE  = 3'd0;
  localparam logic [2:0] OP_READ   = 3'd1;
  localparam logic [2:0] OP_SET    = 3'd2;
  localparam logic [2:0] OP_OUT    = 3'd3;
  localparam logic [2:0] OP_WAIT   = 3'd4;
  localparam logic [2:0] OP_TOGGLE = 3'd5;

  // input vector bits that the table changes
  localparam logic [16:0] IN_SAMPLE     = 17'h00001;
  localparam logic [16:0] IN_OVERRUN    = 17'h00200;
  localparam logic [16:0] IN_INFO_EMPTY = 17'h00400;
  localparam logic [16:0] IN_TX_STATE_Q = 17'h10000;

  // observed output bits
  localparam logic [7:0] OB_IRQ_N  = 8'h01;
  localparam logic [7:0] OB_RESET  = 8'h02;
  localparam logic [7:0] OB_TX_REQ = 8'h04;
  localparam logic [7:0] OB_LO_ST_AF = 8'h38;
  localparam logic [7:0] OB_CLKOUT = 8'h40;
  localparam logic [7:0] OB_EXT    = 8'h80;

  // command outputs, selected by GRP_CMD in the addr field
  localparam logic [7:0] GRP_CMD    = 8'h01;
  localparam logic [7:0] OB_CLR_OVR = 8'h01;
  localparam logic [7:0] OB_RELEASE = 8'h02;
  localparam logic [7:0] OB_ABORT   = 8'h04;
  localparam logic [7:0] OB_SELF_RX = 8'h08;
  localparam logic [7:0] OB_SINGLE  = 8'h10;

  // for OUT and WAIT rows the data field holds the output mask and addr the group
  typedef struct packed {
    logic [2:0]  op;
    logic [7:0]  addr;
    logic [7:0]  data;
    logic [16:0] vec;
    logic [7:0]  exp;
  } row_t;

  logic               clk;
  logic               rst;
  logic               re;
  logic               we;
  can_reg_pkg::byte_t addr_read;
  can_reg_pkg::byte_t addr_write;
  can_reg_pkg::byte_t data_in;
  logic [16:0]        in_vec;
  can_reg_pkg::byte_t data_out;
  logic               irq_n;
  logic               clkout;
  logic               extended_mode;
  logic               reset_mode;
  logic               listen_only_mode;
  logic               acceptance_filter_mode;
  logic               self_test_mode;
  logic               clear_data_overrun;
  logic               release_buffer;
  logic               abort_tx;
  logic               tx_request;
  logic               self_rx_request;
  logic               single_shot_transmission;
  logic [7:0]         obs;
  logic [7:0]         cmd_obs;
  row_t               rows [0:MAX_ROWS-1];
  int                 num_rows;

  assign obs = {extended_mode, clkout, acceptance_filter_mode, self_test_mode,
                listen_only_mode, tx_request, reset_mode, irq_n};
  assign cmd_obs = {3'b000, single_shot_transmission, self_rx_request, abort_tx,
                    release_buffer, clear_data_overrun};

  can_registers i_dut (
    .clk, .rst, .re, .we, .addr_read, .addr_write, .data_in,
    .sample_point(in_vec[0]), .transmitting(in_vec[1]), .set_reset_mode(in_vec[2]),
    .node_bus_off(in_vec[3]), .error_status(in_vec[4]), .transmit_status(in_vec[5]),
    .receive_status(in_vec[6]), .tx_successful(in_vec[7]), .need_to_tx(in_vec[8]),
    .overrun(in_vec[9]), .info_empty(in_vec[10]), .set_bus_error_irq(in_vec[11]),
    .set_arbitration_lost_irq(in_vec[12]), .node_error_passive(in_vec[13]),
    .node_error_active(in_vec[14]), .tx_state(in_vec[15]), .tx_state_q(in_vec[16]),
    .data_out, .irq_n, .clkout, .extended_mode, .reset_mode, .listen_only_mode,
    .acceptance_filter_mode, .self_test_mode, .clear_data_overrun, .release_buffer,
    .abort_tx, .tx_request, .self_rx_request, .single_shot_transmission
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                             input string msg);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s, got 0x%02h, expected 0x%02h",
               $time, msg, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // advance to the next sample point just before a rising edge
  task automatic wait_sample();
    @(posedge clk);
    #(CLK_PERIOD - SAMPLE_LEAD);
  endtask

  // output group for OUT and WAIT rows
  function automatic logic [7:0] select_outputs(input logic [7:0] group);
    return (group == GRP_CMD) ? cmd_obs : obs;
  endfunction

  task automatic add_row(input logic [2:0] op, input logic [7:0] addr, input logic [7:0] data,
                         input logic [16:0] vec, input logic [7:0] exp);
    rows[num_rows] = {op, addr, data, vec, exp};
    num_rows++;
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  task automatic load_table();
    // reset values in basic mode readback
    add_row(OP_READ, can_reg_pkg::ADDR_MODE, 8'h00, '0, 8'h21);
    add_row(OP_READ, can_reg_pkg::ADDR_STATUS, 8'h00, '0, 8'h0c);
    add_row(OP_OUT, 8'h00, OB_IRQ_N | OB_RESET, '0, 8'h03);
    add_row(OP_READ, can_reg_pkg::ADDR_COMMAND, 8'h00, '0, 8'hff);
    add_row(OP_READ, can_reg_pkg::ADDR_IRQ, 8'h00, '0, 8'he0);
    add_row(OP_READ, 8'd5, 8'h00, '0, 8'h00);
    // switch to extended mode and set the mode options
    add_row(OP_WRITE, can_reg_pkg::ADDR_CLOCK_DIV, 8'h80, '0, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_MODE, 8'h00, '0, 8'h01);
    add_row(OP_READ, can_reg_pkg::ADDR_CLOCK_DIV, 8'h00, '0, 8'h80);
    add_row(OP_OUT, 8'h00, OB_EXT, '0, OB_EXT);
    add_row(OP_WRITE, can_reg_pkg::ADDR_MODE, 8'h0f, '0, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_MODE, 8'h00, '0, 8'h0f);
    add_row(OP_OUT, 8'h00, OB_RESET | OB_LO_ST_AF, '0, OB_RESET | OB_LO_ST_AF);
    // leave reset mode and request a transmission
    add_row(OP_WRITE, can_reg_pkg::ADDR_MODE, 8'h00, '0, 8'h00);
    add_row(OP_OUT, 8'h00, OB_RESET | OB_LO_ST_AF, '0, 8'h00);
    add_row(OP_WRITE, can_reg_pkg::ADDR_COMMAND, 8'h01, '0, 8'h00);
    add_row(OP_OUT, 8'h00, OB_TX_REQ, '0, OB_TX_REQ);
    add_row(OP_READ, can_reg_pkg::ADDR_STATUS, 8'h00, '0, 8'h00);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY | IN_SAMPLE, 8'h00);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY, 8'h00);
    add_row(OP_OUT, 8'h00, OB_TX_REQ, '0, 8'h00);
    // abort with no request pending completes at the next sample point
    add_row(OP_WRITE, can_reg_pkg::ADDR_COMMAND, 8'h02, '0, 8'h00);
    add_row(OP_OUT, GRP_CMD, OB_ABORT, '0, OB_ABORT);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY | IN_SAMPLE, 8'h00);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_STATUS, 8'h00, '0, 8'h0c);
    add_row(OP_OUT, GRP_CMD, OB_ABORT, '0, 8'h00);
    // self reception followed by a single-shot request
    add_row(OP_WRITE, can_reg_pkg::ADDR_COMMAND, 8'h10, '0, 8'h00);
    add_row(OP_OUT, 8'h00, OB_TX_REQ, '0, OB_TX_REQ);
    add_row(OP_WRITE, can_reg_pkg::ADDR_COMMAND, 8'h13, '0, 8'h00);
    add_row(OP_OUT, GRP_CMD, OB_ABORT | OB_SELF_RX, '0, OB_SELF_RX);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY | IN_SAMPLE, 8'h00);
    add_row(OP_OUT, GRP_CMD, OB_SELF_RX | OB_SINGLE, '0, OB_SELF_RX | OB_SINGLE);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY | IN_TX_STATE_Q, 8'h00);
    add_row(OP_OUT, GRP_CMD, OB_SELF_RX | OB_SINGLE, '0, 8'h00);
    // receive interrupt and buffer release
    add_row(OP_WRITE, can_reg_pkg::ADDR_IRQ_EN, 8'h01, '0, 8'h00);
    add_row(OP_SET, 8'h00, 8'h00, 17'h00000, 8'h00);
    add_row(OP_WAIT, 8'h00, OB_IRQ_N, '0, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_STATUS, 8'h00, '0, 8'h05);
    add_row(OP_READ, can_reg_pkg::ADDR_IRQ, 8'h00, '0, 8'h01);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY, 8'h00);
    add_row(OP_OUT, 8'h00, OB_IRQ_N, '0, 8'h00);
    add_row(OP_WRITE, can_reg_pkg::ADDR_COMMAND, 8'h04, '0, 8'h00);
    add_row(OP_OUT, GRP_CMD, OB_RELEASE | OB_CLR_OVR, '0, OB_RELEASE);
    add_row(OP_WAIT, 8'h00, OB_IRQ_N, '0, OB_IRQ_N);
    add_row(OP_OUT, GRP_CMD, OB_RELEASE, '0, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_STATUS, 8'h00, '0, 8'h04);
    add_row(OP_READ, can_reg_pkg::ADDR_IRQ, 8'h00, '0, 8'h00);
    // overrun interrupt with clear on read and the clear overrun command
    add_row(OP_WRITE, can_reg_pkg::ADDR_IRQ_EN, 8'h08, '0, 8'h00);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY | IN_OVERRUN, 8'h00);
    add_row(OP_WAIT, 8'h00, OB_IRQ_N, '0, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_STATUS, 8'h00, '0, 8'h06);
    add_row(OP_READ, can_reg_pkg::ADDR_IRQ, 8'h00, '0, 8'h08);
    add_row(OP_READ, can_reg_pkg::ADDR_IRQ, 8'h00, '0, 8'h00);
    add_row(OP_WRITE, can_reg_pkg::ADDR_COMMAND, 8'h08, '0, 8'h00);
    add_row(OP_OUT, GRP_CMD, OB_RELEASE | OB_CLR_OVR, '0, OB_CLR_OVR);
    add_row(OP_SET, 8'h00, 8'h00, IN_INFO_EMPTY, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_STATUS, 8'h00, '0, 8'h04);
    add_row(OP_OUT, 8'h00, OB_IRQ_N, '0, OB_IRQ_N);
    // divider code 0 toggles every clock and clock-off holds it high
    add_row(OP_TOGGLE, 8'h00, 8'h00, '0, 8'h00);
    add_row(OP_TOGGLE, 8'h00, 8'h00, '0, 8'h00);
    add_row(OP_TOGGLE, 8'h00, 8'h00, '0, 8'h00);
    add_row(OP_WRITE, can_reg_pkg::ADDR_MODE, 8'h01, '0, 8'h00);
    add_row(OP_OUT, 8'h00, OB_RESET, '0, OB_RESET);
    add_row(OP_WRITE, can_reg_pkg::ADDR_CLOCK_DIV, 8'h88, '0, 8'h00);
    add_row(OP_READ, can_reg_pkg::ADDR_CLOCK_DIV, 8'h00, '0, 8'h88);
    add_row(OP_OUT, 8'h00, OB_CLKOUT, '0, OB_CLKOUT);
    add_row(OP_OUT, 8'h00, OB_CLKOUT, '0, OB_CLKOUT);
  endtask

  //////////////////////////////////////////////////
  // one row entered 5 ns after a rising edge
  task automatic run_row(input int idx);
    row_t r;
    int   waited;
    logic first_clkout;
    r = rows[idx];
    case (r.op)
      OP_WRITE:
      begin
        we         = 1'b1;
        addr_write = r.addr;
        data_in    = r.data;
      end
      OP_READ:
      begin
        re        = 1'b1;
        addr_read = r.addr;
      end
      OP_SET:
        in_vec = r.vec;
      default:
        ;
    endcase
    #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
    case (r.op)
      OP_READ:
        check_value(data_out, r.exp, $sformatf("row %0d read data", idx));
      OP_OUT:
        check_value(select_outputs(r.addr) & r.data, r.exp,
                    $sformatf("row %0d output levels", idx));
      OP_WAIT:
      begin
        waited = 0;
        while (((select_outputs(r.addr) & r.data) != r.exp) && (waited < WAIT_LIMIT))
        begin
          wait_sample();
          waited++;
        end
        if ((select_outputs(r.addr) & r.data) != r.exp)
        begin
          $display("timeout: row %0d saw no output change within %0d cycles", idx, WAIT_LIMIT);
          $display("=== FAIL ===");
          $fatal(1, "wait timed out");
        end
      end
      OP_TOGGLE:
      begin
        first_clkout = clkout;
        wait_sample();
        check_value({7'b0, clkout}, {7'b0, ~first_clkout}, $sformatf("row %0d clkout", idx));
      end
      default:
        ;
    endcase
    @(posedge clk);
    #DRIVE_DELAY;
    we = 1'b0;
    re = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial
  begin
    rst        = 1'b1;
    re         = 1'b0;
    we         = 1'b0;
    addr_read  = '0;
    addr_write = '0;
    data_in    = '0;
    in_vec     = IN_INFO_EMPTY;
    num_rows   = 0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    for (int i = 0; i < num_rows; i++)
      run_row(i);
    $display("=== PASS ===");
    $finish;
  end

  // watchdog sized at 20 cycles per row plus reset
  initial
  begin
    int limit_ns;
    #1;
    limit_ns = (num_rows * 20 + RESET_CYCLES) * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog expired: the table did not finish within %0d ns", limit_ns);
    $display("=== FAIL ===");
    $fatal(1, "watchdog");
  end

endmodule

// File: verilog.f
rtl/can_reg_pkg.sv
rtl/can_mode_cmd.sv
rtl/can_status.sv
rtl/can_irq.sv
rtl/can_clkout.sv
rtl/can_registers.sv
verification/can_registers_tb.sv
